//--- fixp_pkg.sv
package fixp_pkg;

    // vector shape
    localparam int a_len  = 4;
    localparam int b_len  = 4;
    localparam int cell_w = 8;            // a, b and result cells share one width
    localparam int prod_w = 2 * cell_w;   // full signed product

    localparam int a_w      = a_len * cell_w;
    localparam int b_w      = b_len * cell_w;
    localparam int result_w = a_len * b_len * cell_w;

    // tiling, rows of a by columns of b per cycle
    localparam int tile_v     = 2;
    localparam int tile_h     = 2;
    localparam int tile_cells = tile_v * tile_h;

    localparam int n_tiles_v = a_len / tile_v;
    localparam int n_tiles_h = b_len / tile_h;
    localparam int n_tiles   = n_tiles_v * n_tiles_h;

    // tile counter widths, at least one bit
    localparam int row_cnt_w = (n_tiles_v > 1) ? $clog2(n_tiles_v) : 1;
    localparam int col_cnt_w = (n_tiles_h > 1) ? $clog2(n_tiles_h) : 1;

    localparam int shift_w = 3;           // fraction shift 0..7

    // saturation limits of a result cell
    localparam logic [cell_w-1:0] cell_max = {1'b0, {(cell_w - 1){1'b1}}};
    localparam logic [cell_w-1:0] cell_min = {1'b1, {(cell_w - 1){1'b0}}};

endpackage

//--- op_ctrl_pkg.sv
package op_ctrl_pkg;

    // engine FSM
    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_calc = 2'd1,
        st_done = 2'd2
    } engine_state_t;

    // configuration register map
    typedef enum logic [1:0] {
        reg_frac      = 2'd0,   // fraction shift
        reg_mode      = 2'd1,   // bit 0 selects saturate
        reg_ovf_count = 2'd2    // jobs that overflowed
    } reg_addr_t;

    localparam int cfg_data_w = 8;

    ////////////////////////////////////////////////////////////
    // reset values
    ////////////////////////////////////////////////////////////
    localparam logic [fixp_pkg::shift_w-1:0] frac_reset = 3'd4;
    localparam logic                         mode_reset = 1'b0;   // wrap

    localparam int ovf_count_w = 8;

endpackage

//--- outer_product_regs.sv
`timescale 1ns/1ps

module outer_product_regs (
    input  logic                                  clk,
    input  logic                                  rst,
    input  logic                                  cfg_wr,
    input  op_ctrl_pkg::reg_addr_t                cfg_addr,
    input  logic [op_ctrl_pkg::cfg_data_w-1:0]    cfg_wdata,
    output logic [op_ctrl_pkg::cfg_data_w-1:0]    cfg_rdata,
    input  logic                                  busy,
    input  logic                                  job_ovf,
    output logic [fixp_pkg::shift_w-1:0]          frac_shift,
    output logic                                  sat_en
);

    logic [fixp_pkg::shift_w-1:0]        frac_q;
    logic                                sat_q;
    logic [op_ctrl_pkg::ovf_count_w-1:0] ovf_cnt_q;
    logic                                wr_en;

    assign wr_en = cfg_wr && !busy;   // config is frozen during a job

    ////////////////////////////////////////////////////////////
    // writable fields
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            frac_q <= op_ctrl_pkg::frac_reset;
            sat_q  <= op_ctrl_pkg::mode_reset;
        end else if (wr_en) begin
            case (cfg_addr)
                op_ctrl_pkg::reg_frac: frac_q <= cfg_wdata[fixp_pkg::shift_w-1:0];
                op_ctrl_pkg::reg_mode: sat_q  <= cfg_wdata[0];
                default: ;
            endcase
        end
    end

    // overflow job counter, sticks at all ones
    always_ff @(posedge clk) begin
        if (rst) begin
            ovf_cnt_q <= '0;
        end else if (wr_en && cfg_addr == op_ctrl_pkg::reg_ovf_count) begin
            ovf_cnt_q <= '0;   // any write clears
        end else if (job_ovf && ovf_cnt_q != '1) begin
            ovf_cnt_q <= ovf_cnt_q + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // readback
    ////////////////////////////////////////////////////////////
    always_comb begin
        cfg_rdata = '0;
        case (cfg_addr)
            op_ctrl_pkg::reg_frac:      cfg_rdata[fixp_pkg::shift_w-1:0] = frac_q;
            op_ctrl_pkg::reg_mode:      cfg_rdata[0] = sat_q;
            op_ctrl_pkg::reg_ovf_count: cfg_rdata[op_ctrl_pkg::ovf_count_w-1:0] = ovf_cnt_q;
            default: ;
        endcase
    end

    assign frac_shift = frac_q;
    assign sat_en     = sat_q;

endmodule

//--- operand_capture.sv
`timescale 1ns/1ps

module operand_capture (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [fixp_pkg::a_w-1:0] a,
    input  logic                     a_valid,
    output logic                     a_ready,
    input  logic [fixp_pkg::b_w-1:0] b,
    input  logic                     b_valid,
    output logic                     b_ready,
    input  logic                     job_done,
    output logic [fixp_pkg::a_w-1:0] a_buf,
    output logic [fixp_pkg::b_w-1:0] b_buf,
    output logic                     operands_ready
);

    logic                     a_set_q;
    logic                     b_set_q;
    logic [fixp_pkg::a_w-1:0] a_buf_q;
    logic [fixp_pkg::b_w-1:0] b_buf_q;

    assign a_ready = ~a_set_q;   // one vector held at a time
    assign b_ready = ~b_set_q;

    // set flags, released when the result leaves
    always_ff @(posedge clk) begin
        if (rst) begin
            a_set_q <= 1'b0;
            b_set_q <= 1'b0;
        end else if (job_done) begin
            a_set_q <= 1'b0;
            b_set_q <= 1'b0;
        end else begin
            if (a_valid && a_ready)
                a_set_q <= 1'b1;
            if (b_valid && b_ready)
                b_set_q <= 1'b1;
        end
    end

    // operand payload
    always_ff @(posedge clk) begin
        if (a_valid && a_ready)
            a_buf_q <= a;
        if (b_valid && b_ready)
            b_buf_q <= b;
    end

    assign a_buf          = a_buf_q;
    assign b_buf          = b_buf_q;
    assign operands_ready = a_set_q && b_set_q;

endmodule

//--- tile_multiplier.sv
`timescale 1ns/1ps

module tile_multiplier (
    input  logic [fixp_pkg::tile_v*fixp_pkg::cell_w-1:0]     a_tile,
    input  logic [fixp_pkg::tile_h*fixp_pkg::cell_w-1:0]     b_tile,
    input  logic [fixp_pkg::shift_w-1:0]                     frac_shift,
    input  logic                                             sat_en,
    output logic [fixp_pkg::tile_cells*fixp_pkg::cell_w-1:0] cells,
    output logic                                             ovf
);

    logic [fixp_pkg::tile_cells-1:0] cell_ovf;

    genvar i, j;
    for (i = 0; i < fixp_pkg::tile_v; i++) begin : g_row
        for (j = 0; j < fixp_pkg::tile_h; j++) begin : g_col
            logic signed [fixp_pkg::prod_w-1:0] prod;
            logic signed [fixp_pkg::prod_w-1:0] shifted;
            logic [fixp_pkg::prod_w-fixp_pkg::cell_w:0] top_bits;
            logic [fixp_pkg::cell_w-1:0] cell_val;

            assign prod = $signed(a_tile[i*fixp_pkg::cell_w +: fixp_pkg::cell_w]) *
                          $signed(b_tile[j*fixp_pkg::cell_w +: fixp_pkg::cell_w]);
            assign shifted = prod >>> frac_shift;   // keeps the sign

            // fits in a cell only if the sign bit and everything above agree
            assign top_bits = shifted[fixp_pkg::prod_w-1:fixp_pkg::cell_w-1];
            assign cell_ovf[i*fixp_pkg::tile_h+j] = ~((&top_bits) | ~(|top_bits));

            always_comb begin
                if (cell_ovf[i*fixp_pkg::tile_h+j] && sat_en) begin
                    // clamp toward the sign of the true value
                    if (shifted[fixp_pkg::prod_w-1])
                        cell_val = fixp_pkg::cell_min;
                    else
                        cell_val = fixp_pkg::cell_max;
                end else begin
                    cell_val = shifted[fixp_pkg::cell_w-1:0];   // wrap
                end
            end

            assign cells[(i*fixp_pkg::tile_h+j)*fixp_pkg::cell_w +: fixp_pkg::cell_w] = cell_val;
        end
    end

    assign ovf = |cell_ovf;

endmodule

//--- outer_product_engine.sv
`timescale 1ns/1ps

module outer_product_engine (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [fixp_pkg::a_w-1:0]      a_buf,
    input  logic [fixp_pkg::b_w-1:0]      b_buf,
    input  logic                          operands_ready,
    input  logic [fixp_pkg::shift_w-1:0]  frac_shift,
    input  logic                          sat_en,
    output logic [fixp_pkg::result_w-1:0] result,
    output logic                          result_valid,
    input  logic                          result_ready,
    output logic                          error,
    output logic                          busy,
    output logic                          job_done,
    output logic                          job_ovf
);

    op_ctrl_pkg::engine_state_t state_q;

    logic [fixp_pkg::row_cnt_w-1:0] row_q;   // tile row, selects a cells
    logic [fixp_pkg::col_cnt_w-1:0] col_q;   // tile column, selects b cells
    logic                           last_col;
    logic                           last_tile;

    logic [fixp_pkg::shift_w-1:0]   frac_q;
    logic                           sat_q;
    logic                           ovf_q;   // sticky over the job

    logic [fixp_pkg::tile_v*fixp_pkg::cell_w-1:0]     a_tile;
    logic [fixp_pkg::tile_h*fixp_pkg::cell_w-1:0]     b_tile;
    logic [fixp_pkg::tile_cells*fixp_pkg::cell_w-1:0] tile_cells;
    logic                                             tile_ovf;
    logic [fixp_pkg::result_w-1:0]                    result_q;

    ////////////////////////////////////////////////////////////
    // tile select and multiply
    ////////////////////////////////////////////////////////////
    assign a_tile = a_buf[row_q*fixp_pkg::tile_v*fixp_pkg::cell_w +:
                          fixp_pkg::tile_v*fixp_pkg::cell_w];
    assign b_tile = b_buf[col_q*fixp_pkg::tile_h*fixp_pkg::cell_w +:
                          fixp_pkg::tile_h*fixp_pkg::cell_w];

    tile_multiplier tile_multiplier_inst (
        .a_tile     (a_tile),
        .b_tile     (b_tile),
        .frac_shift (frac_q),
        .sat_en     (sat_q),
        .cells      (tile_cells),
        .ovf        (tile_ovf)
    );

    assign last_col  = (int'(col_q) == fixp_pkg::n_tiles_h - 1);
    assign last_tile = (int'(row_q) * fixp_pkg::n_tiles_h + int'(col_q)) == fixp_pkg::n_tiles - 1;

    ////////////////////////////////////////////////////////////
    // control FSM
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= op_ctrl_pkg::st_idle;
            row_q   <= '0;
            col_q   <= '0;
            ovf_q   <= 1'b0;
        end else begin
            case (state_q)
                op_ctrl_pkg::st_idle: begin
                    row_q <= '0;
                    col_q <= '0;
                    if (operands_ready) begin
                        state_q <= op_ctrl_pkg::st_calc;
                        ovf_q   <= 1'b0;   // new job
                    end
                end
                op_ctrl_pkg::st_calc: begin
                    ovf_q <= ovf_q | tile_ovf;
                    col_q <= last_col ? '0 : col_q + 1'b1;
                    if (last_col)
                        row_q <= row_q + 1'b1;   // wraps to 0 after the last row
                    if (last_tile)
                        state_q <= op_ctrl_pkg::st_done;
                end
                op_ctrl_pkg::st_done: begin
                    if (result_ready)
                        state_q <= op_ctrl_pkg::st_idle;
                end
                default: state_q <= op_ctrl_pkg::st_idle;
            endcase
        end
    end

    // shift and mode are frozen for the whole job
    always_ff @(posedge clk) begin
        if (state_q == op_ctrl_pkg::st_idle && operands_ready) begin
            frac_q <= frac_shift;
            sat_q  <= sat_en;
        end
    end

    ////////////////////////////////////////////////////////////
    // result matrix, cell (r, c) at index r*b_len + c
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (state_q == op_ctrl_pkg::st_calc) begin
            for (int i = 0; i < fixp_pkg::tile_v; i++) begin
                for (int j = 0; j < fixp_pkg::tile_h; j++) begin
                    result_q[((int'(row_q) * fixp_pkg::tile_v + i) * fixp_pkg::b_len +
                              int'(col_q) * fixp_pkg::tile_h + j) * fixp_pkg::cell_w +:
                             fixp_pkg::cell_w]
                        <= tile_cells[(i*fixp_pkg::tile_h+j)*fixp_pkg::cell_w +: fixp_pkg::cell_w];
                end
            end
        end
    end

    assign result       = result_q;
    assign result_valid = (state_q == op_ctrl_pkg::st_done);
    assign error        = result_valid && ovf_q;   // only meaningful with valid
    assign busy         = (state_q != op_ctrl_pkg::st_idle);
    assign job_done     = result_valid && result_ready;
    assign job_ovf      = job_done && ovf_q;

endmodule

//--- outer_product_top.sv
`timescale 1ns/1ps

module outer_product_top (
    input  logic                                clk,
    input  logic                                rst,
    // operand a
    input  logic [fixp_pkg::a_w-1:0]            a,
    input  logic                                a_valid,
    output logic                                a_ready,
    // operand b
    input  logic [fixp_pkg::b_w-1:0]            b,
    input  logic                                b_valid,
    output logic                                b_ready,
    // result matrix
    output logic [fixp_pkg::result_w-1:0]       result,
    output logic                                result_valid,
    input  logic                                result_ready,
    output logic                                error,
    // configuration
    input  logic                                cfg_wr,
    input  op_ctrl_pkg::reg_addr_t              cfg_addr,
    input  logic [op_ctrl_pkg::cfg_data_w-1:0]  cfg_wdata,
    output logic [op_ctrl_pkg::cfg_data_w-1:0]  cfg_rdata
);

    logic [fixp_pkg::a_w-1:0]     a_buf;
    logic [fixp_pkg::b_w-1:0]     b_buf;
    logic                         operands_ready;
    logic                         job_done;
    logic                         job_ovf;
    logic                         busy;
    logic [fixp_pkg::shift_w-1:0] frac_shift;
    logic                         sat_en;

    outer_product_regs outer_product_regs_inst (
        .clk        (clk),
        .rst        (rst),
        .cfg_wr     (cfg_wr),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg_rdata  (cfg_rdata),
        .busy       (busy),
        .job_ovf    (job_ovf),
        .frac_shift (frac_shift),
        .sat_en     (sat_en)
    );

    operand_capture operand_capture_inst (
        .clk            (clk),
        .rst            (rst),
        .a              (a),
        .a_valid        (a_valid),
        .a_ready        (a_ready),
        .b              (b),
        .b_valid        (b_valid),
        .b_ready        (b_ready),
        .job_done       (job_done),
        .a_buf          (a_buf),
        .b_buf          (b_buf),
        .operands_ready (operands_ready)
    );

    outer_product_engine outer_product_engine_inst (
        .clk            (clk),
        .rst            (rst),
        .a_buf          (a_buf),
        .b_buf          (b_buf),
        .operands_ready (operands_ready),
        .frac_shift     (frac_shift),
        .sat_en         (sat_en),
        .result         (result),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .error          (error),
        .busy           (busy),
        .job_done       (job_done),
        .job_ovf        (job_ovf)
    );

endmodule

//--- outer_product_props.sv
`timescale 1ns/1ps

module outer_product_props (
    input logic                          clk,
    input logic                          rst,
    input logic                          a_valid,
    input logic                          a_ready,
    input logic                          b_valid,
    input logic                          b_ready,
    input logic [fixp_pkg::result_w-1:0] result,
    input logic                          result_valid,
    input logic                          result_ready,
    input logic                          error
);

    int   fail_count = 0;   // read by the testbench
    logic a_hs;
    logic b_hs;
    logic last_hs;
    logic result_hs;

    assign a_hs      = a_valid && a_ready;
    assign b_hs      = b_valid && b_ready;
    assign result_hs = result_valid && result_ready;
    // edge after which both operands are held
    assign last_hs   = (a_hs || b_hs) && (a_hs || !b_ready) && (b_hs || !a_ready);

    ////////////////////////////////////////////////////////////
    // handshake and timing rules
    ////////////////////////////////////////////////////////////
    hold_result: assert property (@(posedge clk) disable iff (rst)
        result_valid && !result_ready |=> result_valid && $stable(result) && $stable(error))
        else begin fail_count++; $error("result changed under back-pressure"); end

    a_ready_drop: assert property (@(posedge clk) disable iff (rst) a_hs |=> !a_ready)
        else begin fail_count++; $error("a_ready high after a was taken"); end

    a_ready_hold: assert property (@(posedge clk) disable iff (rst)
        !a_ready && !result_hs |=> !a_ready)
        else begin fail_count++; $error("a_ready rose before the result handshake"); end

    b_ready_drop: assert property (@(posedge clk) disable iff (rst) b_hs |=> !b_ready)
        else begin fail_count++; $error("b_ready high after b was taken"); end

    b_ready_hold: assert property (@(posedge clk) disable iff (rst)
        !b_ready && !result_hs |=> !b_ready)
        else begin fail_count++; $error("b_ready rose before the result handshake"); end

    // valid rises five cycles after the accepting edge and shows at the sixth sample
    latency: assert property (@(posedge clk) disable iff (rst) last_hs |-> ##6 $rose(result_valid))
        else begin fail_count++; $error("result latency is not 5 cycles"); end

    reset_quiet: assert property (@(posedge clk) rst |=> !result_valid && !error)
        else begin fail_count++; $error("result_valid or error high after reset"); end

endmodule

bind outer_product_top outer_product_props outer_product_props_inst (
    .clk          (clk),
    .rst          (rst),
    .a_valid      (a_valid),
    .a_ready      (a_ready),
    .b_valid      (b_valid),
    .b_ready      (b_ready),
    .result       (result),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .error        (error)
);

//--- outer_product_tb.sv
`timescale 1ns/1ps

module outer_product_tb;

    localparam int planned_jobs = 227;
    localparam int cycle_limit  = 40 * planned_jobs + 200;

    logic                               clk = 1'b0;
    logic                               rst;
    logic [fixp_pkg::a_w-1:0]           a;
    logic                               a_valid;
    logic                               a_ready;
    logic [fixp_pkg::b_w-1:0]           b;
    logic                               b_valid;
    logic                               b_ready;
    logic [fixp_pkg::result_w-1:0]      result;
    logic                               result_valid;
    logic                               result_ready;
    logic                               error;
    logic                               cfg_wr;
    op_ctrl_pkg::reg_addr_t             cfg_addr;
    logic [op_ctrl_pkg::cfg_data_w-1:0] cfg_wdata;
    logic [op_ctrl_pkg::cfg_data_w-1:0] cfg_rdata;

    logic [fixp_pkg::result_w-1:0] exp_result_q[$];   // one entry per job in flight
    logic                          exp_error_q[$];
    logic [7:0]                    exp_frac_q[$];
    logic [31:0]                   lcg_state = 32'h4f6c;
    logic [fixp_pkg::shift_w-1:0]  cur_frac;
    logic                          cur_sat;
    int                            ovf_jobs    = 0;
    int                            ready_mode  = 0;   // 0 ready, 1 random stalls, 2 held low
    int                            stall_left  = 0;
    int                            cycle_count = 0;

    outer_product_top outer_product_top_inst (
        .clk(clk), .rst(rst), .a(a), .a_valid(a_valid), .a_ready(a_ready),
        .b(b), .b_valid(b_valid), .b_ready(b_ready),
        .result(result), .result_valid(result_valid), .result_ready(result_ready),
        .error(error), .cfg_wr(cfg_wr), .cfg_addr(cfg_addr),
        .cfg_wdata(cfg_wdata), .cfg_rdata(cfg_rdata)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        return int'((lcg_next() >> 16) % n);   // high bits, the low ones repeat fast
    endfunction

    function automatic logic [31:0] rand_word();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = 16'(rand_below(65536));
        lo = 16'(rand_below(65536));
        return {hi, lo};
    endfunction

    // expected matrix from the cell rule, ovf set when any cell leaves -128..127
    function automatic logic [fixp_pkg::result_w-1:0] expected_matrix(
        input logic [fixp_pkg::a_w-1:0] av, input logic [fixp_pkg::b_w-1:0] bv,
        input int shift, input logic sat, output logic ovf);
        logic [fixp_pkg::result_w-1:0] m;
        logic [fixp_pkg::cell_w-1:0]   c;
        int                            p;
        ovf = 1'b0;
        m   = '0;
        for (int i = 0; i < fixp_pkg::a_len; i++) begin
            for (int j = 0; j < fixp_pkg::b_len; j++) begin
                p = $signed(av[i*fixp_pkg::cell_w +: fixp_pkg::cell_w]) *
                    $signed(bv[j*fixp_pkg::cell_w +: fixp_pkg::cell_w]);
                p = p >>> shift;
                c = p[fixp_pkg::cell_w-1:0];
                if (p > 127 || p < -128) begin
                    ovf = 1'b1;
                    if (sat)
                        c = (p > 0) ? 8'h7f : 8'h80;
                end
                m[(i*fixp_pkg::b_len + j)*fixp_pkg::cell_w +: fixp_pkg::cell_w] = c;
            end
        end
        return m;
    endfunction

    task automatic stop_run(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_result(input logic [fixp_pkg::result_w-1:0] got, exp);
        if (got !== exp)
            stop_run($sformatf("[ERROR] %0t: result %h, expected %h", $time, got, exp));
    endtask

    task automatic check_error(input logic got, exp);
        if (got !== exp)
            stop_run($sformatf("[ERROR] %0t: error flag %b, expected %b", $time, got, exp));
    endtask

    task automatic check_reg(input op_ctrl_pkg::reg_addr_t addr,
                             input logic [op_ctrl_pkg::cfg_data_w-1:0] got, exp);
        if (got !== exp)
            stop_run($sformatf("[ERROR] %0t: register %s reads %h, expected %h",
                               $time, addr.name(), got, exp));
    endtask

    ////////////////////////////////////////////////////////////
    // stimulus tasks
    ////////////////////////////////////////////////////////////
    task automatic drain();
        while (exp_result_q.size() != 0)
            @(posedge clk);
    endtask

    task automatic write_reg(input op_ctrl_pkg::reg_addr_t addr, input logic [7:0] data);
        @(posedge clk);
        cfg_wr    <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_wr    <= 1'b0;
        cfg_addr  <= op_ctrl_pkg::reg_frac;   // compare process reads the shift here
    endtask

    task automatic read_check(input op_ctrl_pkg::reg_addr_t addr, input logic [7:0] exp);
        @(posedge clk);
        cfg_addr <= addr;
        @(negedge clk);
        check_reg(addr, cfg_rdata, exp);
        @(posedge clk);
        cfg_addr <= op_ctrl_pkg::reg_frac;
    endtask

    task automatic configure(input logic [fixp_pkg::shift_w-1:0] frac, input logic sat);
        drain();
        write_reg(op_ctrl_pkg::reg_frac, {5'b0, frac});
        write_reg(op_ctrl_pkg::reg_mode, {7'b0, sat});
        cur_frac = frac;
        cur_sat  = sat;
    endtask

    task automatic send_a(input logic [fixp_pkg::a_w-1:0] v, input int gap);
        @(posedge clk);
        repeat (gap) @(posedge clk);
        a       <= v;
        a_valid <= 1'b1;
        do @(posedge clk); while (!a_ready);
        a_valid <= 1'b0;
    endtask

    task automatic send_b(input logic [fixp_pkg::b_w-1:0] v, input int gap);
        @(posedge clk);
        repeat (gap) @(posedge clk);
        b       <= v;
        b_valid <= 1'b1;
        do @(posedge clk); while (!b_ready);
        b_valid <= 1'b0;
    endtask

    // queue the expectation, then offer a and b in random order
    task automatic run_job(input logic [fixp_pkg::a_w-1:0] av, input logic [fixp_pkg::b_w-1:0] bv);
        logic exp_ovf;
        int   gap_a;
        int   gap_b;
        gap_a = rand_below(4);
        gap_b = rand_below(4);
        exp_result_q.push_back(expected_matrix(av, bv, int'(cur_frac), cur_sat, exp_ovf));
        exp_error_q.push_back(exp_ovf);
        exp_frac_q.push_back({5'b0, cur_frac});
        if (exp_ovf)
            ovf_jobs++;
        fork
            send_a(av, gap_a);
            send_b(bv, gap_b);
        join
    endtask

    always @(posedge clk) begin
        if (ready_mode == 1) begin
            if (stall_left > 0) begin
                stall_left--;
                result_ready <= 1'b0;
            end else begin
                stall_left = rand_below(6);   // next low stretch
                result_ready <= 1'b1;
            end
        end else begin
            result_ready <= (ready_mode == 0);
        end
    end

    // compare on each result handshake
    always @(negedge clk) begin
        if (outer_product_top_inst.outer_product_props_inst.fail_count != 0)
            stop_run("a bound assertion failed");
        if (!rst && result_valid && result_ready) begin
            if (exp_result_q.size() == 0) begin
                stop_run("result handshake with no job pending");
            end else begin
                check_result(result, exp_result_q.pop_front());
                check_error(error, exp_error_q.pop_front());
                check_reg(op_ctrl_pkg::reg_frac, cfg_rdata, exp_frac_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit)
            stop_run($sformatf("timeout: run did not finish within %0d cycles", cycle_limit));
    end

    initial begin
        rst          = 1'b1;
        a            = '0;
        a_valid      = 1'b0;
        b            = '0;
        b_valid      = 1'b0;
        result_ready = 1'b1;
        cfg_wr       = 1'b0;
        cfg_addr     = op_ctrl_pkg::reg_frac;
        cfg_wdata    = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        read_check(op_ctrl_pkg::reg_frac, 8'd4);
        read_check(op_ctrl_pkg::reg_mode, 8'd0);
        read_check(op_ctrl_pkg::reg_ovf_count, 8'd0);
        cur_frac = op_ctrl_pkg::frac_reset;
        cur_sat  = 1'b0;
        run_job(32'h2008_f010, 32'h18fc_0410);   // small values, no overflow at shift 4

        repeat (200) begin
            configure(3'(rand_below(8)), 1'(rand_below(2)));
            run_job(rand_word(), rand_word());
        end

        ////////////////////////////////////////////////////////////
        // overflow in both modes, then the job counter
        ////////////////////////////////////////////////////////////
        drain();
        write_reg(op_ctrl_pkg::reg_ovf_count, 8'h00);
        ovf_jobs = 0;
        configure(3'd0, 1'b1);
        run_job(32'h807f_7f80, 32'h7f80_807f);
        run_job(32'h7f7f_7f7f, 32'h8080_8080);
        configure(3'd0, 1'b0);
        run_job(32'h807f_7f80, 32'h7f80_807f);
        run_job(32'h7f7f_7f7f, 32'h8080_8080);
        drain();
        read_check(op_ctrl_pkg::reg_ovf_count, 8'(ovf_jobs));
        write_reg(op_ctrl_pkg::reg_ovf_count, 8'hff);   // any write clears
        read_check(op_ctrl_pkg::reg_ovf_count, 8'd0);

        // back-pressure, next operands offered while the result waits
        configure(3'(rand_below(8)), 1'b1);
        ready_mode = 1;
        repeat (20) run_job(rand_word(), rand_word());
        drain();
        ready_mode = 0;

        // write while the result is held must not land
        configure(3'd3, 1'b0);
        ready_mode = 2;
        run_job(rand_word(), rand_word());
        while (!result_valid)
            @(posedge clk);
        write_reg(op_ctrl_pkg::reg_frac, 8'd7);
        read_check(op_ctrl_pkg::reg_frac, 8'd3);
        ready_mode = 0;
        run_job(rand_word(), rand_word());   // still expects shift 3
        drain();

        if (outer_product_top_inst.outer_product_props_inst.fail_count != 0) begin
            $display("bound assertions failed during the run");
            $display("Testbench failed");
            $fatal(1, "assertion failures");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

//--- flist.f
fixp_pkg.sv
op_ctrl_pkg.sv
outer_product_regs.sv
operand_capture.sv
tile_multiplier.sv
outer_product_engine.sv
outer_product_top.sv
outer_product_props.sv
outer_product_tb.sv
